//--- verilog/fpu_settings.svh
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// Float data width
`define FPU_FLEN      32

// Architectural float registers
`define FPU_NUM_REGS  32
`define FPU_REG_AW    5

// Single precision field layout
`define FPU_EXP_W     8
`define FPU_MANT_W    23
`define FPU_EXP_BIAS  127

`endif

//--- verilog/fpu_pkg.sv
`include "fpu_settings.svh"

package fpu_pkg;

   typedef logic [`FPU_FLEN-1:0]         f_data_t;
   typedef logic [`FPU_REG_AW-1:0]       f_reg_addr_t;
   // Working exponent with room for carry and a negative result
   typedef logic signed [`FPU_EXP_W+1:0] f_exp_t;
   // Mantissa with the hidden one restored
   typedef logic [`FPU_MANT_W:0]         f_mant_t;
   typedef logic [2*`FPU_MANT_W+1:0]     f_prod_t;
   typedef logic [3:0]                   fiu_op_t;

   // R-type field split, also used for S-type stores
   typedef struct packed {
      logic [6:0]  funct7;
      f_reg_addr_t rs2;
      f_reg_addr_t rs1;
      logic [2:0]  funct3;
      f_reg_addr_t rd;
      logic [6:0]  opcode;
   } f_instr_t;

   localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
   localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
   localparam logic [6:0] OPC_OP_FP    = 7'b1010011;

   localparam logic [6:0] F7_FMUL      = 7'b0001000;
   localparam logic [6:0] F7_FSGNJ     = 7'b0010000;
   localparam logic [6:0] F7_FMINMAX   = 7'b0010100;
   localparam logic [6:0] F7_FCMP      = 7'b1010000;
   localparam logic [6:0] F7_FMVXW     = 7'b1110000;
   localparam logic [6:0] F7_FMVWX     = 7'b1111000;

   localparam logic [2:0] F3_WORD      = 3'b010;

   localparam fiu_op_t FIU_SGNJ  = 4'd0;
   localparam fiu_op_t FIU_SGNJN = 4'd1;
   localparam fiu_op_t FIU_SGNJX = 4'd2;
   localparam fiu_op_t FIU_MIN   = 4'd3;
   localparam fiu_op_t FIU_MAX   = 4'd4;
   localparam fiu_op_t FIU_EQ    = 4'd5;
   localparam fiu_op_t FIU_LT    = 4'd6;
   localparam fiu_op_t FIU_LE    = 4'd7;
   localparam fiu_op_t FIU_MVXW  = 4'd8;
   localparam fiu_op_t FIU_MVWX  = 4'd9;

   typedef struct packed {
      fiu_op_t fiu_op;
      logic    op_reads_frf1;
      logic    op_reads_frf2;
      logic    op_reads_rf1;
      logic    op_writes_frf;
      logic    op_writes_rf;
      logic    is_fmul_op;
      logic    is_load_op;
      logic    is_store_op;
   } f_decode_s;

   typedef struct packed {
      f_instr_t  instruction;
      f_decode_s decode;
   } f_id_s;

   typedef struct packed {
      f_instr_t  instruction;
      f_decode_s decode;
      f_data_t   frs1_val;
      f_data_t   frs2_val;
   } f_exe_s;

   typedef struct packed {
      f_reg_addr_t frd_addr;
      f_decode_s   decode;
      f_data_t     fiu_result;
   } f_mem_s;

   // Shared by WB and WB1
   typedef struct packed {
      logic        op_writes_frf;
      logic        is_fmul_op;
      f_reg_addr_t frd_addr;
      f_data_t     frf_data;
   } f_wb_s;

endpackage

//--- verilog/float_decode.sv
module float_decode
(
   input  fpu_pkg::f_instr_t  instr_i,
   input  logic               instr_v_i,
   output fpu_pkg::f_decode_s decode_o
);
   import fpu_pkg::*;

   f_decode_s dec;
   logic      legal;

   always_comb
   begin
      dec   = '0;
      legal = 1'b0;
      case (instr_i.opcode)
         OPC_LOAD_FP:
         begin
            legal             = (instr_i.funct3 == F3_WORD);
            dec.op_writes_frf = 1'b1;
            dec.is_load_op    = 1'b1;
         end
         OPC_STORE_FP:
         begin
            // Store data comes from the rs2 field
            legal             = (instr_i.funct3 == F3_WORD);
            dec.op_reads_frf2 = 1'b1;
            dec.is_store_op   = 1'b1;
         end
         OPC_OP_FP:
         begin
            case (instr_i.funct7)
               F7_FMUL:
               begin
                  // Any rm value runs as round toward zero
                  legal             = 1'b1;
                  dec.op_reads_frf1 = 1'b1;
                  dec.op_reads_frf2 = 1'b1;
                  dec.op_writes_frf = 1'b1;
                  dec.is_fmul_op    = 1'b1;
               end
               F7_FSGNJ:
               begin
                  legal             = (instr_i.funct3 <= 3'b010);
                  dec.op_reads_frf1 = 1'b1;
                  dec.op_reads_frf2 = 1'b1;
                  dec.op_writes_frf = 1'b1;
                  case (instr_i.funct3)
                     3'b000:  dec.fiu_op = FIU_SGNJ;
                     3'b001:  dec.fiu_op = FIU_SGNJN;
                     default: dec.fiu_op = FIU_SGNJX;
                  endcase
               end
               F7_FMINMAX:
               begin
                  legal             = (instr_i.funct3 <= 3'b001);
                  dec.op_reads_frf1 = 1'b1;
                  dec.op_reads_frf2 = 1'b1;
                  dec.op_writes_frf = 1'b1;
                  dec.fiu_op        = instr_i.funct3[0] ? FIU_MAX : FIU_MIN;
               end
               F7_FCMP:
               begin
                  legal             = (instr_i.funct3 <= 3'b010);
                  dec.op_reads_frf1 = 1'b1;
                  dec.op_reads_frf2 = 1'b1;
                  dec.op_writes_rf  = 1'b1;
                  case (instr_i.funct3)
                     3'b010:  dec.fiu_op = FIU_EQ;
                     3'b001:  dec.fiu_op = FIU_LT;
                     default: dec.fiu_op = FIU_LE;
                  endcase
               end
               F7_FMVXW:
               begin
                  legal             = (instr_i.funct3 == 3'b000) && (instr_i.rs2 == '0);
                  dec.op_reads_frf1 = 1'b1;
                  dec.op_writes_rf  = 1'b1;
                  dec.fiu_op        = FIU_MVXW;
               end
               F7_FMVWX:
               begin
                  legal             = (instr_i.funct3 == 3'b000) && (instr_i.rs2 == '0);
                  dec.op_reads_rf1  = 1'b1;
                  dec.op_writes_frf = 1'b1;
                  dec.fiu_op        = FIU_MVWX;
               end
               default:
                  legal = 1'b0;
            endcase
         end
         default:
            legal = 1'b0;
      endcase
      // Unknown or absent instruction becomes a bubble
      decode_o = (instr_v_i && legal) ? dec : '0;
   end

endmodule

//--- verilog/float_regfile.sv
`include "fpu_settings.svh"

module float_regfile
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 we_i,
   input  fpu_pkg::f_reg_addr_t waddr_i,
   input  fpu_pkg::f_data_t     wdata_i,
   input  fpu_pkg::f_reg_addr_t raddr1_i,
   input  fpu_pkg::f_reg_addr_t raddr2_i,
   output fpu_pkg::f_data_t     rdata1_o,
   output fpu_pkg::f_data_t     rdata2_o
);
   import fpu_pkg::*;

   f_data_t regs [`FPU_NUM_REGS];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < `FPU_NUM_REGS; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (we_i)
      begin
         regs[waddr_i] <= wdata_i;
      end
   end

   // Write-through, a reader of the register being written sees the new value
   assign rdata1_o = (we_i && (raddr1_i == waddr_i)) ? wdata_i : regs[raddr1_i];
   assign rdata2_o = (we_i && (raddr2_i == waddr_i)) ? wdata_i : regs[raddr2_i];

endmodule

//--- verilog/fiu.sv
module fiu
(
   input  fpu_pkg::fiu_op_t op_i,
   input  fpu_pkg::f_data_t frs1_i,
   input  fpu_pkg::f_data_t frs2_i,
   input  fpu_pkg::f_data_t int_i,
   output fpu_pkg::f_data_t result_o
);
   import fpu_pkg::*;

   localparam int SB = $bits(f_data_t) - 1;

   logic          sign_a;
   logic          sign_b;
   logic [SB-1:0] mag_a;
   logic [SB-1:0] mag_b;
   logic          both_zero;
   logic          ordered_lt;
   logic          equal;

   assign sign_a    = frs1_i[SB];
   assign sign_b    = frs2_i[SB];
   assign mag_a     = frs1_i[SB-1:0];
   assign mag_b     = frs2_i[SB-1:0];
   assign both_zero = (mag_a == '0) && (mag_b == '0);
   // Plus and minus zero compare equal
   assign equal     = (frs1_i == frs2_i) || both_zero;

   // Total order on sign and magnitude, -0 sits below +0
   always_comb
   begin
      if (sign_a != sign_b)
         ordered_lt = sign_a;
      else if (sign_a)
         ordered_lt = mag_a > mag_b;
      else
         ordered_lt = mag_a < mag_b;
   end

   always_comb
   begin
      case (op_i)
         FIU_SGNJ:  result_o = {sign_b, mag_a};
         FIU_SGNJN: result_o = {~sign_b, mag_a};
         FIU_SGNJX: result_o = {sign_a ^ sign_b, mag_a};
         FIU_MIN:   result_o = ordered_lt ? frs1_i : frs2_i;
         FIU_MAX:   result_o = ordered_lt ? frs2_i : frs1_i;
         FIU_EQ:    result_o = f_data_t'(equal);
         FIU_LT:    result_o = f_data_t'(ordered_lt && !both_zero);
         FIU_LE:    result_o = f_data_t'((ordered_lt && !both_zero) || equal);
         FIU_MVXW:  result_o = frs1_i;
         FIU_MVWX:  result_o = int_i;
         default:   result_o = '0;
      endcase
   end

endmodule

//--- verilog/fmul_pipe.sv
`include "fpu_settings.svh"

module fmul_pipe
(
   input  logic             clk,
   input  logic             reset,
   input  logic             en_i,
   input  logic             start_i,
   input  fpu_pkg::f_data_t a_i,
   input  fpu_pkg::f_data_t b_i,
   output fpu_pkg::f_data_t product_o
);
   import fpu_pkg::*;

   localparam int EW = `FPU_EXP_W;
   localparam int MW = `FPU_MANT_W;
   localparam int SB = `FPU_FLEN - 1;

   logic [EW-1:0] a_exp;
   logic [EW-1:0] b_exp;

   // Stage 1, operands unpacked
   logic          s1_valid;
   logic          s1_sign;
   logic          s1_zero;
   f_exp_t        s1_exp;
   f_mant_t       s1_mant_a;
   f_mant_t       s1_mant_b;

   // Stage 2, raw mantissa product
   logic          s2_valid;
   logic          s2_sign;
   logic          s2_zero;
   f_exp_t        s2_exp;
   f_prod_t       s2_prod;

   // Stage 3, packed result
   logic          s3_valid;
   f_data_t       s3_result;

   logic          norm_shift;
   f_exp_t        res_exp;
   logic [MW-1:0] res_mant;
   logic          underflow;

   assign a_exp = a_i[SB-1 -: EW];
   assign b_exp = b_i[SB-1 -: EW];

   // Product of 1.x by 1.y lies in [1,4), so one bit of normalization is enough
   assign norm_shift = s2_prod[2*MW+1];
   assign res_exp    = s2_exp + $signed({{(EW+1){1'b0}}, norm_shift});
   assign res_mant   = norm_shift ? s2_prod[2*MW -: MW] : s2_prod[2*MW-1 -: MW];
   assign underflow  = res_exp[EW+1] || (res_exp == '0);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
         s3_valid <= 1'b0;
      end
      else if (en_i)
      begin
         s1_valid <= start_i;
         s2_valid <= s1_valid;
         s3_valid <= s2_valid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (en_i)
      begin
         s1_sign   <= a_i[SB] ^ b_i[SB];
         // Zero and subnormal inputs both count as zero
         s1_zero   <= (a_exp == '0) || (b_exp == '0);
         s1_exp    <= $signed({2'b00, a_exp}) + $signed({2'b00, b_exp})
                      - f_exp_t'(`FPU_EXP_BIAS);
         s1_mant_a <= {1'b1, a_i[MW-1:0]};
         s1_mant_b <= {1'b1, b_i[MW-1:0]};

         s2_sign   <= s1_sign;
         s2_zero   <= s1_zero;
         s2_exp    <= s1_exp;
         s2_prod   <= s1_mant_a * s1_mant_b;

         // Truncation gives round toward zero, tiny results flush to signed zero
         if (s2_zero || underflow)
            s3_result <= {s2_sign, {SB{1'b0}}};
         else
            s3_result <= {s2_sign, res_exp[EW-1:0], res_mant};
      end
   end

   assign product_o = s3_valid ? s3_result : '0;

endmodule

//--- verilog/fpi.sv
module fpi
(
   input  logic              clk,
   input  logic              reset,
   input  fpu_pkg::f_instr_t instr_i,
   input  logic              instr_v_i,
   input  logic              stall_i,
   input  logic              flush_i,
   input  fpu_pkg::f_data_t  int_operand_i,
   input  fpu_pkg::f_data_t  load_data_i,
   output fpu_pkg::f_data_t  int_result_o,
   output logic              int_valid_o,
   output fpu_pkg::f_data_t  store_data_o,
   output logic              store_valid_o,
   output logic              dep_stall_o
);
   import fpu_pkg::*;

   f_id_s     id;
   f_exe_s    exe;
   f_mem_s    mem;
   f_wb_s     wb;
   f_wb_s     wb1;

   f_decode_s id_decode;
   logic      rs1_mul_dep;
   logic      rs2_mul_dep;
   logic      dep_stall;
   logic      frf_we;
   f_data_t   frf_rs1;
   f_data_t   frf_rs2;
   f_data_t   mem_data;
   f_data_t   wb1_data;
   f_data_t   frs1_fwd;
   f_data_t   frs2_fwd;
   f_data_t   fiu_int;
   f_data_t   fiu_result;
   f_data_t   fmul_product;

   // A multiply result is not ready before WB1
   function automatic logic mul_pending(f_reg_addr_t addr, f_exe_s e, f_mem_s m, f_wb_s w);
      logic hit;
      hit = (e.decode.is_fmul_op && (addr == e.instruction.rd))
         || (m.decode.is_fmul_op && (addr == m.frd_addr))
         || (w.is_fmul_op && (addr == w.frd_addr));
      return hit;
   endfunction

   // Youngest producer wins
   function automatic f_data_t forward(
      f_reg_addr_t addr,
      f_data_t     reg_val,
      f_mem_s      m,
      f_data_t     m_data,
      f_wb_s       w,
      f_wb_s       w1,
      f_data_t     w1_data
   );
      f_data_t val;
      if (m.decode.op_writes_frf && (addr == m.frd_addr))
         val = m_data;
      else if (w.op_writes_frf && (addr == w.frd_addr))
         val = w.frf_data;
      else if (w1.op_writes_frf && (addr == w1.frd_addr))
         val = w1_data;
      else
         val = reg_val;
      return val;
   endfunction

   float_decode u_decode
   (
      .instr_i   (instr_i),
      .instr_v_i (instr_v_i),
      .decode_o  (id_decode)
   );

   assign rs1_mul_dep = id.decode.op_reads_frf1 && mul_pending(id.instruction.rs1, exe, mem, wb);
   assign rs2_mul_dep = id.decode.op_reads_frf2 && mul_pending(id.instruction.rs2, exe, mem, wb);
   assign dep_stall   = rs1_mul_dep || rs2_mul_dep;

   // Flush drops the ID instruction and the one being offered
   always_ff @(posedge clk)
   begin
      if (reset)
         id <= '0;
      else if (!stall_i)
      begin
         if (flush_i)
            id <= '0;
         else if (!dep_stall)
            id <= '{instruction: instr_i, decode: id_decode};
      end
   end

   assign frf_we = wb1.op_writes_frf && !stall_i;

   float_regfile u_frf
   (
      .clk      (clk),
      .reset    (reset),
      .we_i     (frf_we),
      .waddr_i  (wb1.frd_addr),
      .wdata_i  (wb1_data),
      .raddr1_i (id.instruction.rs1),
      .raddr2_i (id.instruction.rs2),
      .rdata1_o (frf_rs1),
      .rdata2_o (frf_rs2)
   );

   // Bubble into EXE while ID waits on a multiply
   always_ff @(posedge clk)
   begin
      if (reset)
         exe <= '0;
      else if (!stall_i)
      begin
         if (flush_i || dep_stall)
            exe <= '0;
         else
            exe <= '{instruction: id.instruction, decode: id.decode,
                     frs1_val: frf_rs1, frs2_val: frf_rs2};
      end
   end

   assign mem_data = mem.decode.is_load_op ? load_data_i : mem.fiu_result;
   assign wb1_data = wb1.is_fmul_op ? fmul_product : wb1.frf_data;

   always_comb
   begin
      frs1_fwd = forward(exe.instruction.rs1, exe.frs1_val, mem, mem_data, wb, wb1, wb1_data);
      frs2_fwd = forward(exe.instruction.rs2, exe.frs2_val, mem, mem_data, wb, wb1, wb1_data);
   end

   // Integer operand only matters for FMV.W.X
   assign fiu_int = exe.decode.op_reads_rf1 ? int_operand_i : '0;

   fiu u_fiu
   (
      .op_i     (exe.decode.fiu_op),
      .frs1_i   (frs1_fwd),
      .frs2_i   (frs2_fwd),
      .int_i    (fiu_int),
      .result_o (fiu_result)
   );

   // Started from EXE so the product lines up with WB1
   fmul_pipe u_fmul
   (
      .clk       (clk),
      .reset     (reset),
      .en_i      (!stall_i),
      .start_i   (exe.decode.is_fmul_op),
      .a_i       (frs1_fwd),
      .b_i       (frs2_fwd),
      .product_o (fmul_product)
   );

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         mem <= '0;
         wb  <= '0;
         wb1 <= '0;
      end
      else if (!stall_i)
      begin
         mem <= '{frd_addr: exe.instruction.rd, decode: exe.decode, fiu_result: fiu_result};
         wb  <= '{op_writes_frf: mem.decode.op_writes_frf, is_fmul_op: mem.decode.is_fmul_op,
                  frd_addr: mem.frd_addr, frf_data: mem_data};
         wb1 <= wb;
      end
   end

   assign int_result_o  = fiu_result;
   assign store_data_o  = frs2_fwd;
   // One strobe per instruction even when EXE is held
   assign int_valid_o   = exe.decode.op_writes_rf && !stall_i;
   assign store_valid_o = exe.decode.is_store_op && !stall_i;
   assign dep_stall_o   = dep_stall;

endmodule

//--- sim/fpi_tb.sv
module fpi_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import fpu_pkg::*;

   localparam int CLK_PERIOD = 10;
   localparam int MAX_INSTR  = 400;

   // Side data owed to an accepted FLW (MEM) or FMV.W.X (EXE)
   typedef struct packed {
      logic     is_load;
      f_data_t  data;
      logic [2:0] age;
   } side_t;

   logic     clk;
   logic     reset;
   f_instr_t instr_i;
   logic     instr_v_i;
   logic     stall_i;
   logic     flush_i;
   f_data_t  int_operand_i;
   f_data_t  load_data_i;
   f_data_t  int_result_o;
   logic     int_valid_o;
   f_data_t  store_data_o;
   logic     store_valid_o;
   logic     dep_stall_o;

   logic [31:0] lfsr = 32'd32104;
   f_data_t     fr [32];
   f_data_t     int_q [$];
   f_data_t     store_q [$];
   side_t       pend [$];
   logic        stall_en = 1'b0;
   logic        saw_dep = 1'b0;
   logic        reset_q = 1'b1;
   int          cyc = 0;

   fpi u_dut
   (
      .clk           (clk),
      .reset         (reset),
      .instr_i       (instr_i),
      .instr_v_i     (instr_v_i),
      .stall_i       (stall_i),
      .flush_i       (flush_i),
      .int_operand_i (int_operand_i),
      .load_data_i   (load_data_i),
      .int_result_o  (int_result_o),
      .int_valid_o   (int_valid_o),
      .store_data_o  (store_data_o),
      .store_valid_o (store_valid_o),
      .dep_stall_o   (dep_stall_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("Test FAILED");
      $fatal(1, "Simulation stopped");
   endtask

   // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   function automatic f_data_t rand_float();
      logic        sgn;
      logic [7:0]  ex;
      logic [22:0] man;
      sgn = (lfsr_bits(1) != 0);
      ex  = 8'(64 + lfsr_bits(7) % 127);
      man = 23'(lfsr_bits(23));
      return {sgn, ex, man};
   endfunction

   function automatic f_reg_addr_t rand_reg();
      return f_reg_addr_t'(1 + lfsr_bits(3) % 7);
   endfunction

   function automatic f_instr_t enc(logic [6:0] f7, f_reg_addr_t rs2, f_reg_addr_t rs1,
                                    logic [2:0] f3, f_reg_addr_t rd, logic [6:0] opc);
      f_instr_t ins;
      ins.funct7 = f7;
      ins.rs2    = rs2;
      ins.rs1    = rs1;
      ins.funct3 = f3;
      ins.rd     = rd;
      ins.opcode = opc;
      return ins;
   endfunction

   // Reference multiply that truncates and flushes zero and tiny values
   function automatic f_data_t ref_mul(f_data_t a, f_data_t b);
      logic [47:0] p;
      logic [22:0] m;
      logic        s;
      int          e;
      f_data_t     res;
      s   = a[31] ^ b[31];
      p   = 48'({1'b1, a[22:0]}) * 48'({1'b1, b[22:0]});
      e   = int'(a[30:23]) + int'(b[30:23]) - 127;
      if (p[47])
      begin
         e = e + 1;
         m = p[46:24];
      end
      else
         m = p[45:23];
      if (a[30:23] == 0 || b[30:23] == 0 || e <= 0)
         res = {s, 31'b0};
      else
         res = {s, 8'(e), m};
      return res;
   endfunction

   // Order on sign and magnitude with -0 below +0
   function automatic logic order_below(f_data_t a, f_data_t b);
      if (a[31] != b[31])
         return a[31];
      return a[31] ? (a[30:0] > b[30:0]) : (a[30:0] < b[30:0]);
   endfunction

   function automatic logic same_value(f_data_t a, f_data_t b);
      return (a == b) || (a[30:0] == 0 && b[30:0] == 0);
   endfunction

   task automatic model_apply(input f_instr_t ins, input f_data_t side);
      f_data_t a;
      f_data_t b;
      logic    lt;
      a  = fr[ins.rs1];
      b  = fr[ins.rs2];
      lt = order_below(a, b) && !(a[30:0] == 0 && b[30:0] == 0);
      if (ins.opcode == OPC_LOAD_FP)
         fr[ins.rd] = side;
      else if (ins.opcode == OPC_STORE_FP)
         store_q.push_back(b);
      else
         case (ins.funct7)
            F7_FMUL:    fr[ins.rd] = ref_mul(a, b);
            F7_FSGNJ:   fr[ins.rd] = {(ins.funct3 == 3'b000) ? b[31] :
                                      (ins.funct3 == 3'b001) ? ~b[31] : a[31] ^ b[31], a[30:0]};
            F7_FMINMAX: fr[ins.rd] = (order_below(a, b) ^ ins.funct3[0]) ? a : b;
            F7_FCMP:    int_q.push_back(f_data_t'((ins.funct3 == 3'b010) ? same_value(a, b) :
                                                  (ins.funct3 == 3'b001) ? lt :
                                                  (lt || same_value(a, b))));
            F7_FMVXW:   int_q.push_back(a);
            default:    fr[ins.rd] = side;
         endcase
   endtask

   // One rising edge from a falling edge; ages count unstalled edges
   task automatic edge_step(input logic offering, output logic taken);
      stall_i = stall_en ? (lfsr_bits(2) == 0) : 1'b0;
      if (dep_stall_o)
         saw_dep = 1'b1;
      taken = offering && !stall_i && !flush_i && !dep_stall_o;
      @(posedge clk);
      if (!stall_i)
      begin
         foreach (pend[i])
            pend[i].age = pend[i].age + 3'd1;
         while (pend.size() > 0 && pend[0].age >= 3)
            void'(pend.pop_front());
      end
   endtask

   task automatic side_step();
      @(negedge clk);
      load_data_i   = '0;
      int_operand_i = '0;
      foreach (pend[i])
      begin
         if (pend[i].is_load && pend[i].age == 2)
            load_data_i = pend[i].data;
         if (!pend[i].is_load && pend[i].age == 1)
            int_operand_i = pend[i].data;
      end
   endtask

   task automatic idle(input int n);
      logic taken;
      repeat (n)
      begin
         edge_step(1'b0, taken);
         side_step();
      end
   endtask

   task automatic issue(input f_instr_t ins, input f_data_t side);
      logic taken;
      instr_i   = ins;
      instr_v_i = 1'b1;
      taken     = 1'b0;
      while (!taken)
      begin
         edge_step(1'b1, taken);
         if (!taken)
            side_step();
      end
      if (ins.opcode == OPC_LOAD_FP || (ins.opcode == OPC_OP_FP && ins.funct7 == F7_FMVWX))
         pend.push_back('{is_load: (ins.opcode == OPC_LOAD_FP), data: side, age: 3'd0});
      model_apply(ins, side);
      side_step();
      instr_v_i = 1'b0;
      instr_i   = '0;
   endtask

   task automatic fsw(input f_reg_addr_t r);
      issue(enc(7'd0, r, 5'd2, F3_WORD, 5'd0, OPC_STORE_FP), '0);
   endtask

   task automatic flw(input f_reg_addr_t r);
      issue(enc(7'd0, 5'd0, 5'd2, F3_WORD, r, OPC_LOAD_FP), rand_float());
   endtask

   task automatic fop(input logic [6:0] f7, input logic [2:0] f3, input f_reg_addr_t rd,
                      input f_reg_addr_t rs1, input f_reg_addr_t rs2, input f_data_t side);
      issue(enc(f7, rs2, rs1, f3, rd, OPC_OP_FP), side);
   endtask

   task automatic random_fiu_op();
      case (lfsr_bits(3) % 7)
         0: fop(F7_FSGNJ, 3'(lfsr_bits(2) % 3), rand_reg(), rand_reg(), rand_reg(), '0);
         1: fop(F7_FMINMAX, 3'(lfsr_bits(1)), rand_reg(), rand_reg(), rand_reg(), '0);
         2: fop(F7_FCMP, 3'(lfsr_bits(2) % 3), 5'd0, rand_reg(), rand_reg(), '0);
         3: fop(F7_FMVXW, 3'd0, 5'd0, rand_reg(), 5'd0, '0);
         4: fop(F7_FMVWX, 3'd0, rand_reg(), 5'd0, 5'd0, rand_float());
         5: fsw(rand_reg());
         default: flw(rand_reg());
      endcase
   endtask

   // Checks at the rising edge see the values of the cycle just ending
   always @(posedge clk)
   begin
      cyc     <= cyc + 1;
      reset_q <= reset;
      if ((reset || reset_q) && cyc > 0)
         assert (!int_valid_o && !store_valid_o && !dep_stall_o)
         else abort_run("A strobe or dep_stall_o was high during or right after reset");
      if (int_valid_o)
      begin
         if (int_q.size() == 0)
            abort_run("int_valid_o rose with no result expected");
         else
            assert (int_result_o == int_q[0])
            else abort_run($sformatf("Mismatch at %0t: int_result_o expected %h, got %h",
                                     $time, int_q[0], int_result_o));
         void'(int_q.pop_front());
      end
      if (store_valid_o)
      begin
         if (store_q.size() == 0)
            abort_run("store_valid_o rose with no store expected");
         else
            assert (store_data_o == store_q[0])
            else abort_run($sformatf("Mismatch at %0t: store_data_o expected %h, got %h",
                                     $time, store_q[0], store_data_o));
         void'(store_q.pop_front());
      end
   end

   initial
   begin
      #(MAX_INSTR * 20 * CLK_PERIOD);
      abort_run("Watchdog expired before the tests finished");
   end

   initial
   begin
      logic        taken;
      f_reg_addr_t r;
      reset         = 1'b1;
      instr_i       = '0;
      instr_v_i     = 1'b0;
      stall_i       = 1'b0;
      flush_i       = 1'b0;
      int_operand_i = '0;
      load_data_i   = '0;
      foreach (fr[i])
         fr[i] = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // Registers read back as zero after reset
      for (int i = 0; i < 4; i++)
         fsw(f_reg_addr_t'(i));

      // Load then read back at distances covering MEM, WB, WB1 and the regfile
      for (int i = 0; i < 12; i++)
      begin
         r = rand_reg();
         flw(r);
         idle(i % 5);
         if (i % 2 == 0)
            fsw(r);
         else
            fop(F7_FMVXW, 3'd0, 5'd0, r, 5'd0, '0);
      end

      repeat (60)
         random_fiu_op();

      // Dependent readers of multiply results
      for (int i = 0; i < 10; i++)
      begin
         r = f_reg_addr_t'(8 + i % 4);
         fop(F7_FMUL, 3'b001, r, rand_reg(), rand_reg(), '0);
         case (i % 3)
            0: fsw(r);
            1: fop(F7_FMVXW, 3'd0, 5'd0, r, 5'd0, '0);
            default:
            begin
               fop(F7_FSGNJ, 3'b010, 5'd12, r, r, '0);
               fsw(5'd12);
            end
         endcase
      end

      // Back-to-back independent multiplies into distinct registers
      for (int i = 0; i < 6; i++)
         fop(F7_FMUL, 3'b001, f_reg_addr_t'(8 + i), rand_reg(), rand_reg(), '0);
      for (int i = 8; i < 14; i++)
         fsw(f_reg_addr_t'(i));

      // Same mix with random stalls from the integer side
      stall_en = 1'b1;
      repeat (60)
         random_fiu_op();
      stall_en = 1'b0;

      // A flushed write must leave f5 unchanged
      idle(6);
      instr_i   = enc(F7_FSGNJ, 5'd5, 5'd5, 3'b001, 5'd5, OPC_OP_FP);
      instr_v_i = 1'b1;
      edge_step(1'b1, taken);
      side_step();
      instr_v_i = 1'b0;
      instr_i   = '0;
      flush_i   = 1'b1;
      edge_step(1'b0, taken);
      side_step();
      flush_i = 1'b0;
      fsw(5'd5);

      idle(10);
      if (int_q.size() != 0 || store_q.size() != 0)
         abort_run("Expected results were never returned by the DUT");
      else if (!saw_dep)
         abort_run("dep_stall_o never rose during the multiply tests");
      else
      begin
         $display("Test OK");
         $finish;
      end
   end

endmodule

//--- files.f
+incdir+verilog
verilog/fpu_pkg.sv
verilog/float_decode.sv
verilog/float_regfile.sv
verilog/fiu.sv
verilog/fmul_pipe.sv
verilog/fpi.sv
sim/fpi_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fpi testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module fpi_tb -o fpi_sim

./obj_dir/fpi_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
   exit 1
fi
exit 0
